// ==== verilog/cpuPkg.sv ====
package cpuPkg;

    localparam int wordWidth = 32;

    // Width of the word address held by the PC
    localparam int pcWidth = 26;

    // Instruction formats
    //   R-type  op[31:26] rs1[25:21] rs2[20:16] rd[15:11] funct[5:0]
    //   I-type  op[31:26] rs1[25:21] rd/rs2[20:16] imm[15:0]
    //   J-type  op[31:26] offset[25:0]
    // Branch, j and jal targets are the current PC plus the immediate
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeqz  = 6'h04,
        opBnez  = 6'h05,
        opAddi  = 6'h08,
        opAndi  = 6'h0c,
        opOri   = 6'h0d,
        opXori  = 6'h0e,
        opJr    = 6'h12,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcode_t;

    // Same encoding as funct[3:0] of R-type instructions
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSll = 4'd5,
        aluSrl = 4'd6,
        aluSlt = 4'd7
    } aluFunc_t;

    typedef enum logic [2:0] {
        stFetch,
        stDecode,
        stExecute,
        stMemory,
        stWriteBack,
        stNextPc
    } ctrlState_t;

    typedef struct packed {
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic [wordWidth-1:0] imm;
        logic                 useImm;
        aluFunc_t             aluFunc;
        logic                 isLoad;
        logic                 isStore;
        logic                 isBranch;
        logic                 branchOnZero;
        logic                 isJump;
        logic                 isLink;
        logic                 isJumpReg;
        logic                 writesReg;
    } decodedInstr_t;

endpackage

// ==== verilog/instructionDecoder.sv ====
`timescale 1ns/10ps

module instructionDecoder (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         decodeEn,
    input  logic [cpuPkg::wordWidth-1:0] instr,
    output cpuPkg::decodedInstr_t        decoded
);
    import cpuPkg::*;

    opcode_t       opcode;
    logic [5:0]    funct;
    decodedInstr_t decodeNext;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = instr[5:0];

    always_comb begin
        decodeNext         = '0;
        decodeNext.rs1     = instr[25:21];
        decodeNext.rs2     = instr[20:16];
        decodeNext.rd      = instr[20:16];
        decodeNext.imm     = {{(wordWidth - 16){instr[15]}}, instr[15:0]};
        decodeNext.aluFunc = aluAdd;
        case (opcode)
            opRType: begin
                decodeNext.rd = instr[15:11];
                // Only the eight defined functs write a register
                if (funct[5:3] == 3'b000) begin
                    decodeNext.aluFunc   = aluFunc_t'(funct[3:0]);
                    decodeNext.writesReg = 1'b1;
                end
            end
            opAddi, opAndi, opOri, opXori: begin
                decodeNext.useImm    = 1'b1;
                decodeNext.writesReg = 1'b1;
                if (opcode == opAndi) begin
                    decodeNext.aluFunc = aluAnd;
                end else if (opcode == opOri) begin
                    decodeNext.aluFunc = aluOr;
                end else if (opcode == opXori) begin
                    decodeNext.aluFunc = aluXor;
                end
            end
            opLw: begin
                decodeNext.useImm    = 1'b1;
                decodeNext.isLoad    = 1'b1;
                decodeNext.writesReg = 1'b1;
            end
            opSw: begin
                decodeNext.useImm  = 1'b1;
                decodeNext.isStore = 1'b1;
            end
            opBeqz, opBnez: begin
                decodeNext.useImm       = 1'b1;
                decodeNext.isBranch     = 1'b1;
                decodeNext.branchOnZero = (opcode == opBeqz);
            end
            opJ, opJal: begin
                decodeNext.imm    = {{(wordWidth - 26){instr[25]}}, instr[25:0]};
                decodeNext.useImm = 1'b1;
                decodeNext.isJump = 1'b1;
                if (opcode == opJal) begin
                    decodeNext.isLink    = 1'b1;
                    decodeNext.writesReg = 1'b1;
                    decodeNext.rd        = 5'd31;
                end
            end
            opJr: begin
                decodeNext.isJump    = 1'b1;
                decodeNext.isJumpReg = 1'b1;
            end
            default: begin
                // Unknown opcodes decode as a no-op
            end
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            decoded <= '0;
        end else if (decodeEn) begin
            decoded <= decodeNext;
        end
    end

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/10ps

module registerFile #(
    parameter int regAddrWidth = 5
) (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic [regAddrWidth-1:0]      rs1,
    input  logic [regAddrWidth-1:0]      rs2,
    input  logic [regAddrWidth-1:0]      rd,
    input  logic                         writeEn,
    input  logic [cpuPkg::wordWidth-1:0] writeData,
    output logic [cpuPkg::wordWidth-1:0] rs1Data,
    output logic [cpuPkg::wordWidth-1:0] rs2Data
);
    import cpuPkg::*;

    localparam int depth = 2 ** regAddrWidth;

    logic [wordWidth-1:0] regs [depth];

    // Asynchronous reads
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    // Register 0 is never written, so it keeps its reset value of zero
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (rd != '0)) begin
            regs[rd] <= writeData;
        end
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/10ps

module alu (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic                         start,
    input  cpuPkg::aluFunc_t             func,
    input  logic [cpuPkg::wordWidth-1:0] opA,
    input  logic [cpuPkg::wordWidth-1:0] opB,
    output logic [cpuPkg::wordWidth-1:0] result
);
    import cpuPkg::*;

    localparam int shiftWidth = $clog2(wordWidth);

    logic [wordWidth-1:0]  value;
    logic [shiftWidth-1:0] shiftAmount;
    logic                  lessThan;

    assign shiftAmount = opB[shiftWidth-1:0];
    assign lessThan    = $signed(opA) < $signed(opB);

    always_comb begin
        case (func)
            aluAdd: begin
                value = opA + opB;
            end
            aluSub: begin
                value = opA - opB;
            end
            aluAnd: begin
                value = opA & opB;
            end
            aluOr: begin
                value = opA | opB;
            end
            aluXor: begin
                value = opA ^ opB;
            end
            aluSll: begin
                value = opA << shiftAmount;
            end
            aluSrl: begin
                value = opA >> shiftAmount;
            end
            aluSlt: begin
                value = {{(wordWidth - 1){1'b0}}, lessThan};
            end
            default: begin
                value = '0;
            end
        endcase
    end

    // Result holds until the next start
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            result <= '0;
        end else if (start) begin
            result <= value;
        end
    end

endmodule

// ==== verilog/programCounter.sv ====
`timescale 1ns/10ps

module programCounter #(
    parameter logic [cpuPkg::pcWidth-1:0] resetPc = '0
) (
    input  logic                       Clock,
    input  logic                       rstN,
    input  logic                       step,
    input  logic                       load,
    input  logic [cpuPkg::pcWidth-1:0] target,
    output logic [cpuPkg::pcWidth-1:0] pc
);

    // Load has priority over step
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (load) begin
            pc <= target;
        end else if (step) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

// ==== verilog/controller.sv ====
`timescale 1ns/10ps

module controller (
    input  logic                         Clock,
    input  logic                         rstN,
    input  cpuPkg::decodedInstr_t        decoded,
    input  logic [cpuPkg::wordWidth-1:0] rs1Data,
    input  logic                         instrLoaded,
    input  logic                         dataLoaded,
    input  logic                         dataStored,
    output logic                         readInstr,
    output logic                         readData,
    output logic                         writeData,
    output logic                         decodeEn,
    output logic                         aluStart,
    output logic                         regWrite,
    output logic                         pcStep,
    output logic                         pcLoad
);
    import cpuPkg::*;

    ctrlState_t state;
    ctrlState_t stateNext;
    logic       fetchDone;
    logic       memDone;
    logic       isMemOp;
    logic       rs1IsZero;
    logic       taken;

    // Pulses only count while the matching request is up
    assign fetchDone = readInstr && instrLoaded;
    assign memDone   = (readData && dataLoaded) || (writeData && dataStored);
    assign isMemOp   = decoded.isLoad || decoded.isStore;

    // Zero test for beqz and bnez
    assign rs1IsZero = (rs1Data == '0);
    assign taken     = decoded.isJump ||
                       (decoded.isBranch && (rs1IsZero == decoded.branchOnZero));

    always_comb begin
        stateNext = state;
        case (state)
            stFetch: begin
                if (fetchDone) begin
                    stateNext = stDecode;
                end
            end
            stDecode: begin
                stateNext = stExecute;
            end
            stExecute: begin
                stateNext = isMemOp ? stMemory : stWriteBack;
            end
            stMemory: begin
                if (memDone) begin
                    stateNext = stWriteBack;
                end
            end
            stWriteBack: begin
                stateNext = stNextPc;
            end
            stNextPc: begin
                stateNext = stFetch;
            end
            default: begin
                stateNext = stFetch;
            end
        endcase
    end

    // Request levels are registered from the next state so they
    // stay low in reset and drop the cycle after their pulse
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state     <= stFetch;
            readInstr <= 1'b0;
            readData  <= 1'b0;
            writeData <= 1'b0;
        end else begin
            state     <= stateNext;
            readInstr <= (stateNext == stFetch);
            readData  <= (stateNext == stMemory) && decoded.isLoad;
            writeData <= (stateNext == stMemory) && decoded.isStore;
        end
    end

    // Instruction word is only valid with the fetch pulse
    assign decodeEn = (state == stFetch) && fetchDone;
    assign aluStart = (state == stExecute);
    assign regWrite = (state == stWriteBack) && decoded.writesReg;
    assign pcLoad   = (state == stNextPc) && taken;
    assign pcStep   = (state == stNextPc) && !taken;

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/10ps

module cpu #(
    parameter logic [cpuPkg::pcWidth-1:0] resetPc = '0
) (
    input  logic                         Clock,
    input  logic                         rstN,
    input  logic [cpuPkg::wordWidth-1:0] instr,
    input  logic                         instrLoaded,
    input  logic [cpuPkg::wordWidth-1:0] dataIn,
    input  logic                         dataLoaded,
    input  logic                         dataStored,
    output logic [cpuPkg::wordWidth-1:0] instrAddr,
    output logic [cpuPkg::wordWidth-1:0] dataAddr,
    output logic [cpuPkg::wordWidth-1:0] dataOut,
    output logic                         readInstr,
    output logic                         readData,
    output logic                         writeData
);
    import cpuPkg::*;

    localparam int regAddrWidth = 5;

    decodedInstr_t        decoded;
    logic                 decodeEn;
    logic                 aluStart;
    logic                 regWrite;
    logic                 pcStep;
    logic                 pcLoad;
    logic [wordWidth-1:0] rs1Data;
    logic [wordWidth-1:0] rs2Data;
    logic [wordWidth-1:0] aluOpA;
    logic [wordWidth-1:0] aluOpB;
    logic [wordWidth-1:0] aluResult;
    logic [wordWidth-1:0] wbData;
    logic [wordWidth-1:0] loadData;
    logic [wordWidth-1:0] pcWord;
    logic [pcWidth-1:0]   pc;
    logic [pcWidth-1:0]   pcPlusOne;
    logic [pcWidth-1:0]   pcTarget;

    assign pcWord    = {{(wordWidth - pcWidth){1'b0}}, pc};
    assign pcPlusOne = pc + 1'b1;
    assign instrAddr = pcWord;

    // Branch and jump targets are computed relative to the PC
    assign aluOpA = (decoded.isBranch || decoded.isJump) ? pcWord : rs1Data;
    assign aluOpB = decoded.useImm ? decoded.imm : rs2Data;

    // Load data is only valid together with dataLoaded
    always_ff @(posedge Clock) begin
        if (readData && dataLoaded) begin
            loadData <= dataIn;
        end
    end

    always_comb begin
        if (decoded.isLoad) begin
            wbData = loadData;
        end else if (decoded.isLink) begin
            wbData = {{(wordWidth - pcWidth){1'b0}}, pcPlusOne};
        end else begin
            wbData = aluResult;
        end
    end

    assign pcTarget = decoded.isJumpReg ? rs1Data[pcWidth-1:0] : aluResult[pcWidth-1:0];
    assign dataAddr = aluResult;
    assign dataOut  = rs2Data;

    instructionDecoder decoder (
        .Clock    (Clock),
        .rstN     (rstN),
        .decodeEn (decodeEn),
        .instr    (instr),
        .decoded  (decoded)
    );

    registerFile #(
        .regAddrWidth (regAddrWidth)
    ) regs (
        .Clock     (Clock),
        .rstN      (rstN),
        .rs1       (decoded.rs1),
        .rs2       (decoded.rs2),
        .rd        (decoded.rd),
        .writeEn   (regWrite),
        .writeData (wbData),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data)
    );

    alu aluUnit (
        .Clock  (Clock),
        .rstN   (rstN),
        .start  (aluStart),
        .func   (decoded.aluFunc),
        .opA    (aluOpA),
        .opB    (aluOpB),
        .result (aluResult)
    );

    programCounter #(
        .resetPc (resetPc)
    ) pcReg (
        .Clock  (Clock),
        .rstN   (rstN),
        .step   (pcStep),
        .load   (pcLoad),
        .target (pcTarget),
        .pc     (pc)
    );

    controller ctrl (
        .Clock       (Clock),
        .rstN        (rstN),
        .decoded     (decoded),
        .rs1Data     (rs1Data),
        .instrLoaded (instrLoaded),
        .dataLoaded  (dataLoaded),
        .dataStored  (dataStored),
        .readInstr   (readInstr),
        .readData    (readData),
        .writeData   (writeData),
        .decodeEn    (decodeEn),
        .aluStart    (aluStart),
        .regWrite    (regWrite),
        .pcStep      (pcStep),
        .pcLoad      (pcLoad)
    );

endmodule

// ==== bench/cpu_properties.sv ====
`timescale 1ns/10ps

module cpu_properties (
    input logic Clock,
    input logic rstN,
    input logic readInstr,
    input logic readData,
    input logic writeData,
    input logic instrLoaded,
    input logic dataLoaded,
    input logic dataStored
);

    // Only one memory request at a time
    assert property (@(posedge Clock) disable iff (!rstN)
        $onehot0({readInstr, readData, writeData}))
        else $error("More than one memory request level is high");

    // A request holds until its completion pulse is seen
    assert property (@(posedge Clock) disable iff (!rstN)
        readInstr && !instrLoaded |=> readInstr)
        else $error("readInstr dropped before instrLoaded");

    assert property (@(posedge Clock) disable iff (!rstN)
        readData && !dataLoaded |=> readData)
        else $error("readData dropped before dataLoaded");

    assert property (@(posedge Clock) disable iff (!rstN)
        writeData && !dataStored |=> writeData)
        else $error("writeData dropped before dataStored");

    assert property (@(posedge Clock)
        !rstN |=> !readInstr && !readData && !writeData)
        else $error("Memory request high during reset");

    // First fetch starts right after reset
    assert property (@(posedge Clock) $rose(rstN) |=> readInstr)
        else $error("readInstr did not rise in the first cycle after reset");

endmodule

bind controller cpu_properties ctrlProps (
    .Clock       (Clock),
    .rstN        (rstN),
    .readInstr   (readInstr),
    .readData    (readData),
    .writeData   (writeData),
    .instrLoaded (instrLoaded),
    .dataLoaded  (dataLoaded),
    .dataStored  (dataStored)
);

// ==== bench/cpuTb.sv ====
`timescale 1ns/10ps

module cpuTb;
    import cpuPkg::*;

    localparam logic [pcWidth-1:0] resetPc = 26'h100;
    localparam int randomLen      = 200;
    localparam int haltIdx        = randomLen + 31;
    localparam int maxInstr       = 300;
    localparam int cyclesPerInstr = 20;
    localparam int clockPeriod    = 4;

    // Slot kinds of the generated program
    localparam int kRType   = 0;
    localparam int kAddi    = 1;
    localparam int kAndi    = 2;
    localparam int kOri     = 3;
    localparam int kXori    = 4;
    localparam int kLw      = 5;
    localparam int kSw      = 6;
    localparam int kBeqz    = 7;
    localparam int kBnez    = 8;
    localparam int kJ       = 9;
    localparam int kJal     = 10;
    localparam int kJrSetup = 11;
    localparam int kJr      = 12;
    localparam int kOther   = 13;

    localparam int memNone  = 0;
    localparam int memLoad  = 1;
    localparam int memStore = 2;

    logic                 Clock;
    logic                 rstN;
    logic [wordWidth-1:0] instr;
    logic                 instrLoaded;
    logic [wordWidth-1:0] dataIn;
    logic                 dataLoaded;
    logic                 dataStored;
    logic [wordWidth-1:0] instrAddr;
    logic [wordWidth-1:0] dataAddr;
    logic [wordWidth-1:0] dataOut;
    logic                 readInstr;
    logic                 readData;
    logic                 writeData;

    int                   seed = 735;
    int                   errorCount = 0;
    int                   checkCount = 0;
    logic                 programDone;
    logic [wordWidth-1:0] progMem [256];
    int                   kind [256];
    logic [wordWidth-1:0] modelRegs [32];
    logic [wordWidth-1:0] modelMem [64];
    logic [pcWidth-1:0]   modelPc;
    int                   memPending;
    logic [wordWidth-1:0] expAddr;
    logic [wordWidth-1:0] expData;

    cpu #(
        .resetPc (resetPc)
    ) dut_i (
        .Clock       (Clock),
        .rstN        (rstN),
        .instr       (instr),
        .instrLoaded (instrLoaded),
        .dataIn      (dataIn),
        .dataLoaded  (dataLoaded),
        .dataStored  (dataStored),
        .instrAddr   (instrAddr),
        .dataAddr    (dataAddr),
        .dataOut     (dataOut),
        .readInstr   (readInstr),
        .readData    (readData),
        .writeData   (writeData)
    );

    always #(clockPeriod / 2) Clock = ~Clock;

    function automatic int unsigned randBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] encodeR(input logic [5:0] funct, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [4:0] rd);
        return {opRType, rs1, rs2, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input opcode_t op, input logic [4:0] rs1,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs1, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(input opcode_t op, input logic [25:0] offset);
        return {op, offset};
    endfunction

    // Forward targets keep the program from looping and never land on a jr
    function automatic int forwardTarget(input int idx);
        int t;
        t = idx + 1 + int'(randBelow(6));
        if (t > randomLen) begin
            t = randomLen;
        end
        while (kind[t] == kJr) begin
            t++;
        end
        return t;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic buildProgram();
        int         opening [13] = '{kRType, kAddi, kAndi, kOri, kXori, kLw, kSw,
                                     kBeqz, kBnez, kJ, kJal, kJrSetup, kJr};
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rc;
        logic [15:0] imm;
        for (int i = 0; i < 256; i++) begin
            kind[i] = kOther;
        end
        for (int i = 0; i < randomLen; i++) begin
            if (i < 13) begin
                kind[i] = opening[i];
            end else begin
                case (randBelow(16))
                    0, 1, 2, 3: kind[i] = kRType;
                    4:          kind[i] = kAddi;
                    5:          kind[i] = kAndi;
                    6:          kind[i] = kOri;
                    7:          kind[i] = kXori;
                    8, 9:       kind[i] = kLw;
                    10, 11:     kind[i] = kSw;
                    12:         kind[i] = kBeqz;
                    13:         kind[i] = kBnez;
                    14:         kind[i] = (randBelow(2) == 0) ? kJ : kJal;
                    default: begin
                        // jr needs its target loaded into r30 just before
                        if (kind[i-1] != kJr) begin
                            kind[i-1] = kJrSetup;
                            kind[i]   = kJr;
                        end else begin
                            kind[i] = kRType;
                        end
                    end
                endcase
            end
        end
        for (int i = 0; i < randomLen; i++) begin
            ra  = 5'(randBelow(32));
            rb  = 5'(randBelow(32));
            rc  = 5'(randBelow(32));
            imm = 16'(randBelow(65536));
            case (kind[i])
                kRType:   progMem[i] = encodeR(6'(randBelow(8)), ra, rb, rc);
                kAddi:    progMem[i] = encodeI(opAddi, ra, rb, imm);
                kAndi:    progMem[i] = encodeI(opAndi, ra, rb, imm);
                kOri:     progMem[i] = encodeI(opOri, ra, rb, imm);
                kXori:    progMem[i] = encodeI(opXori, ra, rb, imm);
                kLw:      progMem[i] = encodeI(opLw, ra, rb, imm);
                kSw:      progMem[i] = encodeI(opSw, ra, rb, imm);
                kBeqz:    progMem[i] = encodeI(opBeqz, ra, 5'd0, 16'(forwardTarget(i) - i));
                kBnez:    progMem[i] = encodeI(opBnez, ra, 5'd0, 16'(forwardTarget(i) - i));
                kJ:       progMem[i] = encodeJ(opJ, 26'(forwardTarget(i) - i));
                kJal:     progMem[i] = encodeJ(opJal, 26'(forwardTarget(i) - i));
                kJrSetup: progMem[i] = encodeI(opAddi, 5'd0, 5'd30,
                                               16'(resetPc + forwardTarget(i + 1)));
                default:  progMem[i] = encodeI(opJr, 5'd30, 5'd0, 16'd0);
            endcase
        end
        // Register dump followed by a jump to itself as the end marker
        for (int k = 1; k < 32; k++) begin
            progMem[randomLen + k - 1] = encodeI(opSw, 5'd0, 5'(k), 16'(k));
        end
        progMem[haltIdx] = encodeJ(opJ, 26'd0);
    endtask

    task automatic writeModelReg(input logic [4:0] idx, input logic [31:0] value);
        if (idx != 5'd0) begin
            modelRegs[idx] = value;
        end
    endtask

    task automatic modelStep(input logic [31:0] word);
        logic [wordWidth-1:0] a;
        logic [wordWidth-1:0] b;
        logic [wordWidth-1:0] immS;
        logic [wordWidth-1:0] res;
        logic [wordWidth-1:0] addr;
        logic [pcWidth-1:0]   nextPc;
        a      = modelRegs[word[25:21]];
        b      = modelRegs[word[20:16]];
        immS   = {{16{word[15]}}, word[15:0]};
        addr   = a + immS;
        nextPc = modelPc + 1'b1;
        case (word[31:26])
            opRType: begin
                case (word[2:0])
                    3'd0:    res = a + b;
                    3'd1:    res = a - b;
                    3'd2:    res = a & b;
                    3'd3:    res = a | b;
                    3'd4:    res = a ^ b;
                    3'd5:    res = a << b[4:0];
                    3'd6:    res = a >> b[4:0];
                    default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
                writeModelReg(word[15:11], res);
            end
            opAddi: writeModelReg(word[20:16], a + immS);
            opAndi: writeModelReg(word[20:16], a & immS);
            opOri:  writeModelReg(word[20:16], a | immS);
            opXori: writeModelReg(word[20:16], a ^ immS);
            opLw: begin
                memPending = memLoad;
                expAddr    = addr;
                expData    = modelMem[addr[5:0]];
                writeModelReg(word[20:16], expData);
            end
            opSw: begin
                memPending          = memStore;
                expAddr             = addr;
                expData             = b;
                modelMem[addr[5:0]] = b;
            end
            opBeqz: nextPc = (a == '0) ? modelPc + immS[pcWidth-1:0] : nextPc;
            opBnez: nextPc = (a != '0) ? modelPc + immS[pcWidth-1:0] : nextPc;
            opJ:    nextPc = modelPc + word[25:0];
            opJal: begin
                writeModelReg(5'd31, {6'd0, modelPc + 1'b1});
                nextPc = modelPc + word[25:0];
            end
            opJr:   nextPc = a[pcWidth-1:0];
            default: begin
            end
        endcase
        modelPc = nextPc;
    endtask

    task automatic serveFetch();
        int idx;
        if (memPending != memNone) begin
            $display("Error: fetch at 0x%h came before the previous memory access", instrAddr);
            errorCount++;
            memPending = memNone;
        end
        checkValue("instrAddr", instrAddr, {{(wordWidth - pcWidth){1'b0}}, modelPc});
        idx = int'(instrAddr) - int'(resetPc);
        if (idx < 0 || idx > haltIdx) begin
            $display("Error: fetch from 0x%h lies outside the program", instrAddr);
            errorCount++;
            programDone = 1'b1;
        end else if (idx == haltIdx) begin
            programDone = 1'b1;
        end else begin
            instr = progMem[idx];
            modelStep(progMem[int'(modelPc) - int'(resetPc)]);
        end
        instrLoaded = 1'b1;
    endtask

    task automatic serveLoad();
        if (memPending != memLoad) begin
            $display("Error: data read at 0x%h while no load was expected", dataAddr);
            errorCount++;
        end else begin
            checkValue("dataAddr", dataAddr, expAddr);
            dataIn = expData;
        end
        memPending = memNone;
        dataLoaded = 1'b1;
    endtask

    task automatic serveStore();
        if (memPending != memStore) begin
            $display("Error: data write at 0x%h while no store was expected", dataAddr);
            errorCount++;
        end else begin
            checkValue("dataAddr", dataAddr, expAddr);
            checkValue("dataOut", dataOut, expData);
        end
        memPending = memNone;
        dataStored = 1'b1;
    endtask

    // Answers one request at a time after 0 to 3 cycles
    initial begin : memoryResponder
        int delay;
        forever begin
            @(negedge Clock);
            instrLoaded = 1'b0;
            dataLoaded  = 1'b0;
            dataStored  = 1'b0;
            if (rstN && !programDone && (readInstr || readData || writeData)) begin
                delay = int'(randBelow(4));
                repeat (delay) @(negedge Clock);
                if (readInstr) begin
                    serveFetch();
                end else if (readData) begin
                    serveLoad();
                end else begin
                    serveStore();
                end
            end
        end
    end

    initial begin
        Clock       = 1'b0;
        rstN        = 1'b0;
        instr       = '0;
        instrLoaded = 1'b0;
        dataIn      = '0;
        dataLoaded  = 1'b0;
        dataStored  = 1'b0;
        programDone = 1'b0;
        memPending  = memNone;
        modelPc     = resetPc;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        // Fill pattern spreads every address bit
        for (int i = 0; i < 64; i++) begin
            modelMem[i] = 32'h9e37_79b9 * (i + 1);
        end
        buildProgram();
        repeat (10) @(negedge Clock);
        rstN = 1'b1;
        wait (programDone);
        if (memPending != memNone) begin
            $display("Error: the last memory access never happened");
            errorCount++;
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(maxInstr * cyclesPerInstr * clockPeriod);
        $display("Timeout: the core did not reach the end of the program in time");
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== cpu.f ====
verilog/cpuPkg.sv
verilog/instructionDecoder.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/programCounter.sv
verilog/controller.sv
verilog/cpu.sv
bench/cpu_properties.sv
bench/cpuTb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - verilog/cpuPkg.sv
  - verilog/instructionDecoder.sv
  - verilog/registerFile.sv
  - verilog/alu.sv
  - verilog/programCounter.sv
  - verilog/controller.sv
  - verilog/cpu.sv
  - target: test
    files:
      - bench/cpu_properties.sv
      - bench/cpuTb.sv
